// ==== verilog/rp_analog_pkg.sv ====
/*
 * analog datapath package
 * sample widths, converter word types, system-bus sizes,
 * housekeeping register map and identification word
 */

package rp_analog_pkg;

  ////////////////////////////////////////
  // sample types
  ////////////////////////////////////////

  localparam int SMP_W = 14;                        // ADC and DAC resolution

  typedef logic        [SMP_W-1:0] adc_raw_t;       // neg-slope offset binary from pins
  typedef logic signed [SMP_W-1:0] smp_t;           // two's complement sample
  typedef logic        [SMP_W-1:0] dac_code_t;      // neg-slope offset binary to DAC

  ////////////////////////////////////////
  // system bus
  ////////////////////////////////////////

  localparam int SYS_AW = 20;                       // byte address
  localparam int SYS_DW = 32;                       // whole-word data

  // pwm level and shared counter, 256 cycle period
  localparam int PWM_W = 8;

  typedef logic [PWM_W-1:0] pwm_level_t;

  // housekeeping word offsets
  // pwm channel n lives at HK_PWM0 + 4*n, up to HK_PWM_LAST
  typedef enum logic [SYS_AW-1:0] {
    HK_ID       = 'h00,                             // read only
    HK_LOOP     = 'h04,                             // bit 0 loopback enable
    HK_PWM0     = 'h20,
    HK_PWM_LAST = 'h2C
  } hk_reg_e;

  localparam logic [SYS_DW-1:0] HK_ID_VALUE = 32'h5250_0001;

endpackage

// ==== verilog/rp_adc_frontend.sv ====
/*
 * ADC frontend
 * converts neg-slope offset-binary converter words to two's
 * complement and selects the digital loopback path
 */

`timescale 1ns/1ps

module rp_adc_frontend #(
  parameter int NUM_CH = 2                                   // analog channels
) (
  input  logic                                 adc_clk,
  input  logic                                 rst_i,      // active high, synced
  input  rp_analog_pkg::adc_raw_t [NUM_CH-1:0] adc_raw_i,  // raw words from pins
  input  rp_analog_pkg::smp_t     [NUM_CH-1:0] dac_sat_i,  // saturated DAC samples
  input  logic                                 loop_en_i,  // route DAC back to ADC
  output rp_analog_pkg::smp_t     [NUM_CH-1:0] adc_smp_o   // to scope / controller
);

  import rp_analog_pkg::*;

  ////////////////////////////////////////
  // format conversion
  ////////////////////////////////////////

  // converter counts down with rising voltage,
  // so the msb stays and the rest flip
  smp_t adc_conv [NUM_CH];

  always_comb begin
    for (int ch = 0; ch < NUM_CH; ch++) begin
      adc_conv[ch] = {adc_raw_i[ch][SMP_W-1], ~adc_raw_i[ch][SMP_W-2:0]};
    end
  end

  ////////////////////////////////////////
  // loopback mux + output register
  ////////////////////////////////////////

  // one register stage on both paths
  // raw -> smp is 1 cycle, gen/ctl -> smp via loopback is 2
  always_ff @(posedge adc_clk, posedge rst_i) begin
    if (rst_i) begin
      adc_smp_o <= '0;
    end else begin
      for (int ch = 0; ch < NUM_CH; ch++) begin
        if (loop_en_i) begin
          adc_smp_o[ch] <= dac_sat_i[ch];     // digital loopback
        end else begin
          adc_smp_o[ch] <= adc_conv[ch];      // real converter
        end
      end
    end
  end

endmodule

// ==== verilog/rp_dac_backend.sv ====
/*
 * DAC backend
 * sums generator and controller samples per channel, saturates
 * to the DAC range and formats the neg-slope DAC code
 */

`timescale 1ns/1ps

module rp_dac_backend #(
  parameter int NUM_CH = 2                                    // analog channels
) (
  input  logic                                  adc_clk,
  input  logic                                  rst_i,      // active high, synced
  input  rp_analog_pkg::smp_t      [NUM_CH-1:0] gen_smp_i,  // generator samples
  input  rp_analog_pkg::smp_t      [NUM_CH-1:0] ctl_smp_i,  // controller samples
  output rp_analog_pkg::smp_t      [NUM_CH-1:0] dac_sat_o,  // saturated, registered
  output rp_analog_pkg::dac_code_t [NUM_CH-1:0] dac_code_o  // to DAC pins
);

  import rp_analog_pkg::*;

  // DAC code of a zero sample, mid scale in neg slope
  localparam dac_code_t CODE_ZERO = {1'b0, {(SMP_W-1){1'b1}}};

  ////////////////////////////////////////
  // sum and saturate
  ////////////////////////////////////////

  logic signed [SMP_W:0] dac_sum [NUM_CH];    // one guard bit
  smp_t                  dac_sat [NUM_CH];

  always_comb begin
    for (int ch = 0; ch < NUM_CH; ch++) begin
      // sign extended add, cannot overflow at SMP_W+1 bits
      dac_sum[ch] = $signed(gen_smp_i[ch]) + $signed(ctl_smp_i[ch]);

      // top two bits differ -> out of range
      if (dac_sum[ch][SMP_W] ^ dac_sum[ch][SMP_W-1]) begin
        // clamp to +8191 or -8192 by sign of the sum
        dac_sat[ch] = {dac_sum[ch][SMP_W], {(SMP_W-1){~dac_sum[ch][SMP_W]}}};
      end else begin
        dac_sat[ch] = dac_sum[ch][SMP_W-1:0];
      end
    end
  end

  ////////////////////////////////////////
  // output stage
  ////////////////////////////////////////

  // sample and code share one register stage, gen/ctl -> code is 1 cycle
  always_ff @(posedge adc_clk, posedge rst_i) begin
    if (rst_i) begin
      dac_sat_o  <= '0;
      dac_code_o <= {NUM_CH{CODE_ZERO}};      // DAC idles at mid scale
    end else begin
      for (int ch = 0; ch < NUM_CH; ch++) begin
        dac_sat_o[ch]  <= dac_sat[ch];
        // back to neg-slope offset binary
        dac_code_o[ch] <= {dac_sat[ch][SMP_W-1], ~dac_sat[ch][SMP_W-2:0]};
      end
    end
  end

endmodule

// ==== verilog/rp_housekeeping.sv ====
/*
 * housekeeping registers
 * system-bus slave with identification word, loopback enable
 * and the PWM output levels
 */

`timescale 1ns/1ps

module rp_housekeeping #(
  parameter int NUM_PWM = 4                                    // pwm outputs
) (
  input  logic                                    adc_clk,
  input  logic                                    rst_i,       // active high, synced
  // system bus
  input  logic [rp_analog_pkg::SYS_AW-1:0]        sys_addr_i,  // byte address
  input  logic [rp_analog_pkg::SYS_DW-1:0]        sys_wdata_i, // whole-word write data
  input  logic                                    sys_wen_i,   // write strobe
  input  logic                                    sys_ren_i,   // read strobe
  output logic [rp_analog_pkg::SYS_DW-1:0]        sys_rdata_o, // valid with ack
  output logic                                    sys_ack_o,   // one cycle after strobe
  output logic                                    sys_err_o,   // unmapped address
  // configuration
  output logic                                    loop_en_o,
  output rp_analog_pkg::pwm_level_t [NUM_PWM-1:0] pwm_level_o
);

  import rp_analog_pkg::*;

  localparam int IDX_W = (NUM_PWM > 1) ? $clog2(NUM_PWM) : 1;

  ////////////////////////////////////////
  // address decode
  ////////////////////////////////////////

  logic [SYS_AW-1:0] pwm_off;                 // offset into pwm window
  logic [IDX_W-1:0]  pwm_sel;                 // addressed pwm channel
  logic              hit_pwm;
  logic              hit_any;                 // mapped address
  logic [SYS_DW-1:0] rd_mux;

  assign pwm_off = sys_addr_i - HK_PWM0;
  assign pwm_sel = pwm_off[2 +: IDX_W];

  // word aligned, inside the window, and only as many as are built
  assign hit_pwm = (sys_addr_i >= HK_PWM0) && (sys_addr_i <= HK_PWM_LAST)
                && (sys_addr_i[1:0] == 2'b00)
                && (pwm_off[SYS_AW-1:2] < NUM_PWM);

  assign hit_any = (sys_addr_i == HK_ID) || (sys_addr_i == HK_LOOP) || hit_pwm;

  // read data before the register
  always_comb begin
    rd_mux = '0;                              // unmapped reads give zero
    case (sys_addr_i)
      HK_ID:   rd_mux = HK_ID_VALUE;
      HK_LOOP: rd_mux = {{(SYS_DW-1){1'b0}}, loop_en_o};
      default: begin
        if (hit_pwm) begin
          rd_mux = SYS_DW'(pwm_level_o[pwm_sel]);
        end
      end
    endcase
  end

  ////////////////////////////////////////
  // config registers
  ////////////////////////////////////////

  // writes to HK_ID or unmapped space change nothing
  always_ff @(posedge adc_clk, posedge rst_i) begin
    if (rst_i) begin
      loop_en_o   <= 1'b0;
      pwm_level_o <= '0;
    end else if (sys_wen_i) begin
      if (sys_addr_i == HK_LOOP) begin
        loop_en_o <= sys_wdata_i[0];
      end
      if (hit_pwm) begin
        pwm_level_o[pwm_sel] <= sys_wdata_i[PWM_W-1:0];   // upper bits dropped
      end
    end
  end

  ////////////////////////////////////////
  // bus response
  ////////////////////////////////////////

  // single cycle ack and err, no wait states
  always_ff @(posedge adc_clk, posedge rst_i) begin
    if (rst_i) begin
      sys_ack_o   <= 1'b0;
      sys_err_o   <= 1'b0;
      sys_rdata_o <= '0;
    end else begin
      sys_ack_o   <= sys_wen_i | sys_ren_i;
      sys_err_o   <= (sys_wen_i | sys_ren_i) & ~hit_any;
      sys_rdata_o <= sys_ren_i ? rd_mux : '0;           // zero on writes
    end
  end

endmodule

// ==== verilog/rp_pwm_dac.sv ====
/*
 * PWM analog outputs
 * one free-running counter shared by all channels, levels
 * take effect at the start of the next period
 */

`timescale 1ns/1ps

module rp_pwm_dac #(
  parameter int NUM_PWM = 4                                 // pwm outputs
) (
  input  logic                                    adc_clk,
  input  logic                                    rst_i,    // active high, synced
  input  rp_analog_pkg::pwm_level_t [NUM_PWM-1:0] level_i,  // from housekeeping
  output logic                      [NUM_PWM-1:0] pwm_o     // to RC filters
);

  import rp_analog_pkg::*;

  logic [PWM_W-1:0]             pwm_cnt;      // shared period counter
  logic                         pwm_wrap;     // last cycle of period
  pwm_level_t [NUM_PWM-1:0]     pwm_shadow;   // level of current period

  assign pwm_wrap = (pwm_cnt == {PWM_W{1'b1}});

  ////////////////////////////////////////
  // counter and shadow levels
  ////////////////////////////////////////

  always_ff @(posedge adc_clk, posedge rst_i) begin
    if (rst_i) begin
      pwm_cnt    <= '0;
      pwm_shadow <= '0;
      pwm_o      <= '0;
    end else begin
      pwm_cnt <= pwm_cnt + 1'b1;              // rolls over every 256 cycles
      // load on wrap so a period never sees two levels
      if (pwm_wrap) begin
        pwm_shadow <= level_i;
      end
      // registered compare, lags the counter by one cycle
      // level L -> L high cycles, 0 never high, 255 low once
      for (int i = 0; i < NUM_PWM; i++) begin
        pwm_o[i] <= (pwm_cnt < pwm_shadow[i]);
      end
    end
  end

endmodule

// ==== verilog/rp_analog_top.sv ====
/*
 * two channel analog top level on adc_clk
 * reset release, ADC frontend, DAC backend,
 * housekeeping registers and PWM outputs
 */

`timescale 1ns/1ps

module rp_analog_top #(
  parameter int NUM_CH  = 2,                                  // analog channels
  parameter int NUM_PWM = 4                                   // pwm outputs
) (
  input  logic                                   adc_clk,
  input  logic                                   top_rst,     // async, active high
  // analog datapath
  input  rp_analog_pkg::adc_raw_t  [NUM_CH-1:0]  adc_raw_i,   // ADC pins
  input  rp_analog_pkg::smp_t      [NUM_CH-1:0]  gen_smp_i,   // generator
  input  rp_analog_pkg::smp_t      [NUM_CH-1:0]  ctl_smp_i,   // controller
  output rp_analog_pkg::smp_t      [NUM_CH-1:0]  adc_smp_o,   // conditioned ADC
  output rp_analog_pkg::dac_code_t [NUM_CH-1:0]  dac_code_o,  // DAC pins, per channel
  // system bus
  input  logic [rp_analog_pkg::SYS_AW-1:0]       sys_addr_i,
  input  logic [rp_analog_pkg::SYS_DW-1:0]       sys_wdata_i,
  input  logic                                   sys_wen_i,
  input  logic                                   sys_ren_i,
  output logic [rp_analog_pkg::SYS_DW-1:0]       sys_rdata_o,
  output logic                                   sys_ack_o,
  output logic                                   sys_err_o,
  // pwm analog outputs
  output logic [NUM_PWM-1:0]                     pwm_o
);

  import rp_analog_pkg::*;

  ////////////////////////////////////////
  // reset release
  ////////////////////////////////////////

  // asserts with top_rst, drops on the 2nd clock edge after it
  logic [1:0] rst_pipe;
  logic       rst_sync;

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      rst_pipe <= 2'b11;
    end else begin
      rst_pipe <= {rst_pipe[0], 1'b0};
    end
  end

  assign rst_sync = rst_pipe[1];

  ////////////////////////////////////////
  // datapath
  ////////////////////////////////////////

  logic                     loop_en;          // digital loopback
  smp_t       [NUM_CH-1:0]  dac_sat;          // registered saturated samples
  pwm_level_t [NUM_PWM-1:0] pwm_level;

  rp_adc_frontend #(
    .NUM_CH     (NUM_CH)
  ) i_adc (
    .adc_clk    (adc_clk),
    .rst_i      (rst_sync),
    .adc_raw_i  (adc_raw_i),
    .dac_sat_i  (dac_sat),                    // loopback source
    .loop_en_i  (loop_en),
    .adc_smp_o  (adc_smp_o)
  );

  rp_dac_backend #(
    .NUM_CH     (NUM_CH)
  ) i_dac (
    .adc_clk    (adc_clk),
    .rst_i      (rst_sync),
    .gen_smp_i  (gen_smp_i),
    .ctl_smp_i  (ctl_smp_i),
    .dac_sat_o  (dac_sat),
    .dac_code_o (dac_code_o)
  );

  ////////////////////////////////////////
  // housekeeping and pwm
  ////////////////////////////////////////

  rp_housekeeping #(
    .NUM_PWM     (NUM_PWM)
  ) i_hk (
    .adc_clk     (adc_clk),
    .rst_i       (rst_sync),
    .sys_addr_i  (sys_addr_i),
    .sys_wdata_i (sys_wdata_i),
    .sys_wen_i   (sys_wen_i),
    .sys_ren_i   (sys_ren_i),
    .sys_rdata_o (sys_rdata_o),
    .sys_ack_o   (sys_ack_o),
    .sys_err_o   (sys_err_o),
    .loop_en_o   (loop_en),
    .pwm_level_o (pwm_level)
  );

  rp_pwm_dac #(
    .NUM_PWM (NUM_PWM)
  ) i_pwm (
    .adc_clk (adc_clk),                       // pwm shares the ADC clock here
    .rst_i   (rst_sync),
    .level_i (pwm_level),
    .pwm_o   (pwm_o)
  );

endmodule

// ==== verif/tb_rp_analog_table.svh ====
/*
 * analog datapath stimulus table
 * raw ADC words, generator and controller samples and loopback flag
 */

`ifndef TB_RP_ANALOG_TABLE_SVH
`define TB_RP_ANALOG_TABLE_SVH

// column order raw0 raw1 gen0 ctl0 gen1 ctl1 loop, raw0 in the top field
localparam int TBL_ROWS = 10;
localparam int TBL_COLS = 7;
localparam int COL_RAW  = 0;                  // raw word of ch n at COL_RAW + n
localparam int COL_GEN  = 2;                  // gen at COL_GEN + 2n, ctl one above
localparam int COL_LOOP = 6;

function automatic logic [TBL_COLS*SMP_W-1:0] table_row(input int r);
  case (r)
    // idle samples, full scale raw words
    0: return {14'h0000, 14'h3FFF, 14'h0000, 14'h0000, 14'h0000, 14'h0000, 14'h0000};
    // positive overflow, 8191+1 and 4096+4096
    1: return {14'h1FFF, 14'h2000, 14'h1FFF, 14'h0001, 14'h1000, 14'h1000, 14'h0000};
    // negative overflow, -8192-1 and -4096-4097
    2: return {14'h0A5C, 14'h35A3, 14'h2000, 14'h3FFF, 14'h3000, 14'h2FFF, 14'h0000};
    // exact limits +8191 and -8192
    3: return {14'h1234, 14'h2BCD, 14'h1000, 14'h0FFF, 14'h2000, 14'h0000, 14'h0000};
    4: return {14'h0001, 14'h3FFE, 14'h3000, 14'h3000, 14'h0FFF, 14'h1000, 14'h0000};
    // mixed signs, -1 and +35
    5: return {14'h2222, 14'h1DDD, 14'h1FFF, 14'h2000, 14'h0123, 14'h3F00, 14'h0000};
    // loopback rows, raw input must not matter
    6: return {14'h0000, 14'h3FFF, 14'h1FFF, 14'h1FFF, 14'h0005, 14'h3FFB, 14'h0001};
    7: return {14'h1555, 14'h2AAA, 14'h2000, 14'h2000, 14'h2001, 14'h3FFF, 14'h0001};
    8: return {14'h3C3C, 14'h0303, 14'h0FFF, 14'h1001, 14'h07D0, 14'h3830, 14'h0001};
    // back to the converter
    9: return {14'h0800, 14'h3800, 14'h0100, 14'h0200, 14'h3F00, 14'h3F00, 14'h0000};
    default: return '0;
  endcase
endfunction

`endif

// ==== verif/tb_rp_analog_top.sv ====
/*
 * testbench for the two channel analog top level
 * table driven datapath checks, housekeeping bus accesses and PWM duty
 */

`timescale 1ns/1ps

module tb_rp_analog_top;

  import rp_analog_pkg::*;

  localparam int NUM_CH      = 2;
  localparam int NUM_PWM     = 4;
  localparam int RAND_ROWS   = 16;            // random rows after the fixed table
  localparam int ACK_TIMEOUT = 8;             // cycles
  localparam int PWM_TIMEOUT = 600;           // a bit over two periods
  localparam int PWM_FULL    = 2;             // channel with level 255

  `include "tb_rp_analog_table.svh"

  localparam int NUM_ROWS = TBL_ROWS + RAND_ROWS;

  logic                     adc_clk;
  logic                     top_rst;
  adc_raw_t  [NUM_CH-1:0]   adc_raw_i;
  smp_t      [NUM_CH-1:0]   gen_smp_i;
  smp_t      [NUM_CH-1:0]   ctl_smp_i;
  smp_t      [NUM_CH-1:0]   adc_smp_o;
  dac_code_t [NUM_CH-1:0]   dac_code_o;
  logic [SYS_AW-1:0]        sys_addr_i;
  logic [SYS_DW-1:0]        sys_wdata_i;
  logic                     sys_wen_i;
  logic                     sys_ren_i;
  logic [SYS_DW-1:0]        sys_rdata_o;
  logic                     sys_ack_o;
  logic                     sys_err_o;
  logic [NUM_PWM-1:0]       pwm_o;

  logic [SMP_W-1:0] stim [NUM_ROWS][TBL_COLS];  // fixed rows then random ones
  logic             loop_now;                   // loopback state written to DUT
  int               hist_n;                     // rows since last flush
  logic [SMP_W-1:0] conv_d1 [NUM_CH];           // expected, one row back
  logic [SMP_W-1:0] sat_d1  [NUM_CH];
  logic [SMP_W-1:0] sat_d2  [NUM_CH];           // two rows back, loopback path
  pwm_level_t       pwm_lvl [NUM_PWM] = '{8'd37, 8'd0, 8'd255, 8'd128};
  int               high_cnt [NUM_PWM];

  rp_analog_top #(
    .NUM_CH  (NUM_CH),
    .NUM_PWM (NUM_PWM)
  ) dut (
    .adc_clk     (adc_clk),
    .top_rst     (top_rst),
    .adc_raw_i   (adc_raw_i),
    .gen_smp_i   (gen_smp_i),
    .ctl_smp_i   (ctl_smp_i),
    .adc_smp_o   (adc_smp_o),
    .dac_code_o  (dac_code_o),
    .sys_addr_i  (sys_addr_i),
    .sys_wdata_i (sys_wdata_i),
    .sys_wen_i   (sys_wen_i),
    .sys_ren_i   (sys_ren_i),
    .sys_rdata_o (sys_rdata_o),
    .sys_ack_o   (sys_ack_o),
    .sys_err_o   (sys_err_o),
    .pwm_o       (pwm_o)
  );

  initial begin
    adc_clk = 1'b0;
    forever #20 adc_clk = ~adc_clk;           // 40 ns period
  end

  ////////////////////////////////////////
  // reference model and checks
  ////////////////////////////////////////

  // neg-slope offset binary <-> two's complement, flip all but msb
  function automatic logic [SMP_W-1:0] flip_low(input logic [SMP_W-1:0] w);
    return w ^ 14'h1FFF;
  endfunction

  function automatic logic [SMP_W-1:0] sat_sum(input logic [SMP_W-1:0] a,
                                               input logic [SMP_W-1:0] b);
    int s;
    s = $signed(a) + $signed(b);              // full int range, no wrap
    if (s > 8191) begin
      s = 8191;
    end else if (s < -8192) begin
      s = -8192;
    end
    return s[SMP_W-1:0];
  endfunction

  task automatic stop_run(input string why);
    $display("%s (t=%0t)", why, $time);
    $display("=== FAIL ===");
    $fatal(1, "%s", why);
  endtask

  task automatic check_val(input string name, input logic [SYS_DW-1:0] exp_val,
                           input logic [SYS_DW-1:0] act_val);
    if (act_val !== exp_val) begin
      $display("[ERROR] t=%0t %s expected 0x%0h actual 0x%0h",
               $time, name, exp_val, act_val);
      stop_run("value mismatch");
    end
  endtask

  ////////////////////////////////////////
  // system bus
  ////////////////////////////////////////

  // one strobe, then wait for ack, which must come one cycle later
  task automatic bus_access(input logic wr, input logic [SYS_AW-1:0] addr,
                            input logic [SYS_DW-1:0] wdata, input logic exp_err,
                            input logic [SYS_DW-1:0] exp_rdata);
    int   lat;
    logic ack_seen;
    @(posedge adc_clk);
    sys_addr_i  <= addr;
    sys_wdata_i <= wdata;
    sys_wen_i   <= wr;
    sys_ren_i   <= ~wr;
    lat      = 0;
    ack_seen = 1'b0;
    while (!ack_seen) begin
      @(posedge adc_clk);
      sys_wen_i <= 1'b0;                      // single cycle strobe
      sys_ren_i <= 1'b0;
      lat++;
      @(negedge adc_clk);
      ack_seen = sys_ack_o;
      if (!ack_seen && lat >= ACK_TIMEOUT) begin
        stop_run("timeout waiting for sys_ack_o");
      end
    end
    check_val("sys_ack_o latency", 1, lat);
    check_val("sys_err_o", exp_err, sys_err_o);
    check_val("sys_rdata_o", exp_rdata, sys_rdata_o);  // zero on writes
  endtask

  ////////////////////////////////////////
  // datapath rows
  ////////////////////////////////////////

  // drive row r, check outputs of the rows before it
  task automatic apply_row(input int r);
    @(posedge adc_clk);
    for (int ch = 0; ch < NUM_CH; ch++) begin
      adc_raw_i[ch] <= stim[r][COL_RAW + ch];
      gen_smp_i[ch] <= stim[r][COL_GEN + 2*ch];
      ctl_smp_i[ch] <= stim[r][COL_GEN + 2*ch + 1];
    end
    @(negedge adc_clk);
    for (int ch = 0; ch < NUM_CH; ch++) begin
      if (hist_n >= 1) begin
        check_val($sformatf("dac_code_o[%0d]", ch), flip_low(sat_d1[ch]), dac_code_o[ch]);
        if (!loop_now) begin
          check_val($sformatf("adc_smp_o[%0d]", ch), conv_d1[ch],
                    $unsigned(adc_smp_o[ch]));  // raw bits, no sign extension
        end
      end
      if (hist_n >= 2 && loop_now) begin
        check_val($sformatf("adc_smp_o[%0d] loop", ch), sat_d2[ch],
                  $unsigned(adc_smp_o[ch]));
      end
      sat_d2[ch]  = sat_d1[ch];
      sat_d1[ch]  = sat_sum(stim[r][COL_GEN + 2*ch], stim[r][COL_GEN + 2*ch + 1]);
      conv_d1[ch] = flip_low(stim[r][COL_RAW + ch]);
    end
    hist_n++;
  endtask

  // pwm edge wait, bounded
  task automatic wait_pwm(input int idx, input logic val, input string what);
    int n;
    n = 0;
    @(negedge adc_clk);
    while (pwm_o[idx] !== val) begin
      n++;
      if (n >= PWM_TIMEOUT) begin
        stop_run(what);
      end
      @(negedge adc_clk);
    end
  endtask

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////

  initial begin
    logic [TBL_COLS*SMP_W-1:0] row;
    void'($urandom(32'h3ea6_80e2));
    top_rst     = 1'b1;
    adc_raw_i   = {NUM_CH{14'h1FFF}};         // converter code for zero
    gen_smp_i   = '0;
    ctl_smp_i   = '0;
    sys_addr_i  = '0;
    sys_wdata_i = '0;
    sys_wen_i   = 1'b0;
    sys_ren_i   = 1'b0;
    loop_now    = 1'b0;
    hist_n      = 0;

    for (int r = 0; r < TBL_ROWS; r++) begin
      row = table_row(r);
      for (int c = 0; c < TBL_COLS; c++) begin
        stim[r][c] = row[(TBL_COLS-1-c)*SMP_W +: SMP_W];
      end
    end
    for (int r = TBL_ROWS; r < NUM_ROWS; r++) begin
      for (int c = 0; c < COL_LOOP; c++) begin
        stim[r][c] = SMP_W'($urandom());
      end
      stim[r][COL_LOOP] = SMP_W'($urandom() & 1);
    end

    repeat (10) @(posedge adc_clk);
    top_rst <= 1'b0;
    repeat (2) @(posedge adc_clk);            // rst_sync drops on the 2nd edge
    @(negedge adc_clk);
    check_val("sys_ack_o", 0, sys_ack_o);
    check_val("sys_err_o", 0, sys_err_o);
    check_val("pwm_o", 0, pwm_o);
    for (int ch = 0; ch < NUM_CH; ch++) begin
      check_val($sformatf("adc_smp_o[%0d]", ch), 0, adc_smp_o[ch]);
      check_val($sformatf("dac_code_o[%0d]", ch), 14'h1FFF, dac_code_o[ch]);
    end

    // register map
    bus_access(1'b0, HK_ID, '0, 1'b0, HK_ID_VALUE);
    bus_access(1'b1, HK_LOOP, 32'h1, 1'b0, '0);
    bus_access(1'b0, HK_LOOP, '0, 1'b0, 32'h1);
    bus_access(1'b1, HK_LOOP, 32'h0, 1'b0, '0);
    bus_access(1'b0, HK_LOOP, '0, 1'b0, 32'h0);
    for (int i = 0; i < NUM_PWM; i++) begin
      bus_access(1'b1, SYS_AW'(HK_PWM0 + 4*i), SYS_DW'(pwm_lvl[i]), 1'b0, '0);
    end
    for (int i = 0; i < NUM_PWM; i++) begin
      bus_access(1'b0, SYS_AW'(HK_PWM0 + 4*i), '0, 1'b0, SYS_DW'(pwm_lvl[i]));
    end
    bus_access(1'b0, 20'h00008, '0, 1'b1, '0);             // hole in the map
    bus_access(1'b1, 20'h00030, 32'hFFFF_FFFF, 1'b1, '0);  // past last pwm
    bus_access(1'b0, 20'h00022, '0, 1'b1, '0);             // misaligned
    bus_access(1'b1, HK_ID, 32'h0, 1'b0, '0);              // read only
    bus_access(1'b0, HK_ID, '0, 1'b0, HK_ID_VALUE);
    bus_access(1'b0, HK_PWM0, '0, 1'b0, SYS_DW'(pwm_lvl[0]));

    // datapath rows, loopback switched over the bus when a row asks
    for (int r = 0; r < NUM_ROWS; r++) begin
      if (stim[r][COL_LOOP][0] != loop_now) begin
        apply_row(r - 1);                     // drain the pipeline first
        apply_row(r - 1);
        bus_access(1'b1, HK_LOOP, {31'b0, ~loop_now}, 1'b0, '0);
        loop_now = ~loop_now;
        hist_n   = 0;
      end
      apply_row(r);
    end
    apply_row(NUM_ROWS - 1);
    apply_row(NUM_ROWS - 1);

    // pwm duty over one full period
    wait_pwm(PWM_FULL, 1'b1, "timeout waiting for new PWM levels to load");
    wait_pwm(PWM_FULL, 1'b0, "timeout waiting for PWM period boundary");
    for (int i = 0; i < NUM_PWM; i++) begin
      high_cnt[i] = 0;
    end
    for (int k = 0; k < (1 << PWM_W); k++) begin
      @(negedge adc_clk);
      for (int i = 0; i < NUM_PWM; i++) begin
        if (pwm_o[i]) begin
          high_cnt[i]++;
        end
      end
    end
    for (int i = 0; i < NUM_PWM; i++) begin
      check_val($sformatf("pwm_o[%0d] high cycles", i), pwm_lvl[i], high_cnt[i]);
    end

    $display("=== PASS ===");
    $finish;
  end

endmodule

// ==== sim.f ====
+incdir+verif
verilog/rp_analog_pkg.sv
verilog/rp_adc_frontend.sv
verilog/rp_dac_backend.sv
verilog/rp_housekeeping.sv
verilog/rp_pwm_dac.sv
verilog/rp_analog_top.sv
verif/tb_rp_analog_top.sv

// ==== Bender.yml ====
package:
  name: rp_analog

sources:
  - files:
      - verilog/rp_analog_pkg.sv
      - verilog/rp_adc_frontend.sv
      - verilog/rp_dac_backend.sv
      - verilog/rp_housekeeping.sv
      - verilog/rp_pwm_dac.sv
      - verilog/rp_analog_top.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/tb_rp_analog_top.sv
